/* common/mem_if.sv */
`timescale 1ns/1ps

// One core-to-memory port with a waitrequest handshake
interface mem_if;
  import pip_types::*;

  word_t addr;         // Byte address, word aligned
  logic  rd;
  logic  wr;
  word_t wr_data;
  word_t rd_data;
  logic  waitrequest;  // Command held until this is low

  modport cpu (
    output addr, rd, wr, wr_data,
    input  rd_data, waitrequest
  );

  modport mem (
    input  addr, rd, wr, wr_data,
    output rd_data, waitrequest
  );

endinterface

/* common/pip_types.sv */
package pip_types;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Instruction format
  //   [31:26] opcode  [25:21] rd  [20:16] rs1  [15:0] signed immediate
  //   rs2 sits in [15:11] and shares the immediate bits
  // Branch target is branch pc + 4 + (imm << 2)
  localparam int OPCODE_LSB = 26;
  localparam int OPCODE_W   = 6;
  localparam int RD_LSB     = 21;
  localparam int RS1_LSB    = 16;
  localparam int RS2_LSB    = 11;
  localparam int REG_W      = 5;
  localparam int IMM_LSB    = 0;
  localparam int IMM_W      = 16;

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;

  typedef enum logic [OPCODE_W-1:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_SUB  = 6'd2,
    OP_AND  = 6'd3,
    OP_OR   = 6'd4,
    OP_XOR  = 6'd5,
    OP_SLT  = 6'd6,   // Signed compare, rd gets 0 or 1
    OP_ADDI = 6'd7,
    OP_LW   = 6'd8,   // rd = mem[rs1 + imm]
    OP_SW   = 6'd9,   // mem[rs1 + imm] = rs2
    OP_BEQ  = 6'd10,
    OP_BNE  = 6'd11,
    OP_HALT = 6'd12
  } opcode_e;

  typedef struct packed {
    opcode_e   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;        // Sign extended
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      is_branch;
    logic      is_halt;
    logic      uses_rs2;
  } decoded_t;

endpackage

/* logic/core_top.sv */
`timescale 1ns/1ps

module core_top (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 imem_load,
  input  pip_types::word_t     imem_load_addr,
  input  pip_types::word_t     imem_load_data,
  input  logic                 dmem_load,
  input  pip_types::word_t     dmem_load_addr,
  input  pip_types::word_t     dmem_load_data,
  input  pip_types::reg_addr_t dbg_addr,
  output pip_types::word_t     dbg_data,
  output logic                 halted
);
  import pip_types::*;

  reg_addr_t rf_rd_addr1;
  reg_addr_t rf_rd_addr2;
  word_t     rf_rd_data1;
  word_t     rf_rd_data2;
  logic      rf_wr_enable;
  reg_addr_t rf_wr_addr;
  word_t     rf_wr_data;

  mem_if imem_bus ();
  mem_if dmem_bus ();

  pipeline CPU (
    .clock        (clock),
    .reset        (reset),
    .imem         (imem_bus.cpu),
    .dmem         (dmem_bus.cpu),
    .rf_rd_addr1  (rf_rd_addr1),
    .rf_rd_addr2  (rf_rd_addr2),
    .rf_rd_data1  (rf_rd_data1),
    .rf_rd_data2  (rf_rd_data2),
    .rf_wr_enable (rf_wr_enable),
    .rf_wr_addr   (rf_wr_addr),
    .rf_wr_data   (rf_wr_data),
    .halted       (halted)
  );

  rfile REGFILE (
    .clock     (clock),
    .reset     (reset),
    .rd_addr1  (rf_rd_addr1),
    .rd_addr2  (rf_rd_addr2),
    .wr_addr   (rf_wr_addr),
    .dbg_addr  (dbg_addr),
    .wr_enable (rf_wr_enable),
    .wr_data   (rf_wr_data),
    .rd_data1  (rf_rd_data1),
    .rd_data2  (rf_rd_data2),
    .dbg_data  (dbg_data)
  );

  tcm #(.WORDS(IMEM_WORDS)) ITCM (
    .clock     (clock),
    .reset     (reset),
    .cpu       (imem_bus.mem),
    .load      (imem_load),
    .load_addr (imem_load_addr),
    .load_data (imem_load_data)
  );

  tcm #(.WORDS(DMEM_WORDS)) DTCM (
    .clock     (clock),
    .reset     (reset),
    .cpu       (dmem_bus.mem),
    .load      (dmem_load),
    .load_addr (dmem_load_addr),
    .load_data (dmem_load_data)
  );

endmodule

/* logic/rfile.sv */
`timescale 1ns/1ps

module rfile (
  input  logic                 clock,
  input  logic                 reset,
  input  pip_types::reg_addr_t rd_addr1,
  input  pip_types::reg_addr_t rd_addr2,
  input  pip_types::reg_addr_t wr_addr,
  input  pip_types::reg_addr_t dbg_addr,
  input  logic                 wr_enable,
  input  pip_types::word_t     wr_data,
  output pip_types::word_t     rd_data1,
  output pip_types::word_t     rd_data2,
  output pip_types::word_t     dbg_data
);
  import pip_types::*;

  word_t regs_q [32];

  // Write-through read, r0 hardwired to zero
  function automatic word_t read_reg(input reg_addr_t addr);
    if (addr == '0)
      return '0;
    if (wr_enable && wr_addr == addr)
      return wr_data;
    return regs_q[addr];
  endfunction

  assign rd_data1 = read_reg(rd_addr1);
  assign rd_data2 = read_reg(rd_addr2);
  assign dbg_data = read_reg(dbg_addr);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs_q[i] <= '0;
    end else if (wr_enable && wr_addr != '0) begin
      regs_q[wr_addr] <= wr_data;
    end
  end

  // Decoder must already have dropped writes to r0
  a_no_r0_write: assert property (@(posedge clock) disable iff (reset)
    wr_enable |-> wr_addr != '0);

endmodule

/* logic/tcm.sv */
`timescale 1ns/1ps

module tcm #(
  parameter int WORDS = pip_types::IMEM_WORDS
) (
  input  logic             clock,
  input  logic             reset,
  mem_if.mem               cpu,
  input  logic             load,       // Host preload, reset only
  input  pip_types::word_t load_addr,  // Word index
  input  pip_types::word_t load_data
);
  import pip_types::*;

  word_t                    mem_q [WORDS];
  word_t                    rd_data_q;
  logic [$clog2(WORDS)-1:0] idx;
  logic                     active;
  logic                     repeat_access;
  logic                     waited_q;     // Current access has had its wait cycle
  logic                     last_done_q;  // An access completed last cycle
  word_t                    last_addr_q;
  logic [1:0]               last_cmd_q;

  assign idx    = cpu.addr[$clog2(WORDS)+1:2];
  assign active = cpu.rd | cpu.wr;

  // Same access held right after it completed needs no new wait
  assign repeat_access = last_done_q && cpu.addr == last_addr_q &&
                         {cpu.rd, cpu.wr} == last_cmd_q;

  assign cpu.waitrequest = active & ~waited_q & ~repeat_access;
  assign cpu.rd_data     = rd_data_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      waited_q    <= 1'b0;
      last_done_q <= 1'b0;
    end else begin
      waited_q    <= cpu.waitrequest;
      last_done_q <= active & ~cpu.waitrequest;
    end
  end

  always_ff @(posedge clock) begin
    last_addr_q <= cpu.addr;
    last_cmd_q  <= {cpu.rd, cpu.wr};
  end

  // Host load wins over the core port
  always_ff @(posedge clock) begin
    if (load)
      mem_q[load_addr[$clog2(WORDS)-1:0]] <= load_data;
    else if (cpu.wr && !cpu.waitrequest)
      mem_q[idx] <= cpu.wr_data;
    rd_data_q <= mem_q[idx];  // Valid once the address has been stable a cycle
  end

  a_addr_range: assert property (@(posedge clock) disable iff (reset)
    (cpu.rd || cpu.wr) |-> (cpu.addr[31:2] < WORDS) && (cpu.addr[1:0] == 2'b00));

endmodule

/* pip_core.f */
+incdir+test
common/pip_types.sv
common/mem_if.sv
pipeline/decoder.sv
pipeline/pipeline.sv
logic/rfile.sv
logic/tcm.sv
logic/core_top.sv
test/tb_core_top.sv

/* pipeline/decoder.sv */
`timescale 1ns/1ps

module decoder (
  input  pip_types::word_t    instr,
  output pip_types::decoded_t dec
);
  import pip_types::*;

  logic [OPCODE_W-1:0] raw_op;

  assign raw_op = instr[OPCODE_LSB +: OPCODE_W];

  always_comb begin
    dec     = '0;  // Nop with no side effects
    dec.rd  = instr[RD_LSB +: REG_W];
    dec.rs1 = instr[RS1_LSB +: REG_W];
    dec.rs2 = instr[RS2_LSB +: REG_W];
    dec.imm = {{(32-IMM_W){instr[IMM_LSB+IMM_W-1]}}, instr[IMM_LSB +: IMM_W]};

    case (raw_op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
        dec.op        = opcode_e'(raw_op);
        dec.reg_write = 1'b1;
        dec.uses_rs2  = 1'b1;
      end
      OP_ADDI: begin
        dec.op        = OP_ADDI;
        dec.reg_write = 1'b1;
      end
      OP_LW: begin
        dec.op        = OP_LW;
        dec.reg_write = 1'b1;
        dec.mem_read  = 1'b1;
      end
      OP_SW: begin
        dec.op        = OP_SW;
        dec.mem_write = 1'b1;
        dec.uses_rs2  = 1'b1;     // Store data
      end
      OP_BEQ, OP_BNE: begin
        dec.op        = opcode_e'(raw_op);
        dec.is_branch = 1'b1;
        dec.uses_rs2  = 1'b1;
      end
      OP_HALT: begin
        dec.op      = OP_HALT;
        dec.is_halt = 1'b1;
      end
      default: dec.op = OP_NOP;  // Unknown opcodes included
    endcase

    // r0 is never written
    if (dec.rd == '0)
      dec.reg_write = 1'b0;
  end

endmodule

/* pipeline/pipeline.sv */
`timescale 1ns/1ps

module pipeline (
  input  logic                 clock,
  input  logic                 reset,
  mem_if.cpu                   imem,
  mem_if.cpu                   dmem,
  output pip_types::reg_addr_t rf_rd_addr1,
  output pip_types::reg_addr_t rf_rd_addr2,
  input  pip_types::word_t     rf_rd_data1,
  input  pip_types::word_t     rf_rd_data2,
  output logic                 rf_wr_enable,
  output pip_types::reg_addr_t rf_wr_addr,
  output pip_types::word_t     rf_wr_data,
  output logic                 halted
);
  import pip_types::*;

  // Fetch
  word_t    pc_q;
  logic     running_q;     // Fetch enabled
  logic     halted_q;

  // Decode / register read
  logic     d_valid_q;
  word_t    d_instr_q;
  word_t    d_pc_q;
  decoded_t d_dec;

  // Execute
  logic     e_valid_q;
  decoded_t e_dec_q;
  word_t    e_pc_q;
  word_t    e_a_q;
  word_t    e_b_q;
  word_t    fwd_a;
  word_t    fwd_b;
  word_t    alu_res;
  word_t    br_target;
  logic     take_branch;

  // Memory / writeback
  logic     w_valid_q;
  decoded_t w_dec_q;
  word_t    w_alu_q;
  word_t    w_store_q;
  word_t    w_result;
  logic     w_fwd_ok;

  logic     freeze;
  logic     halt_now;

  // Any port still waiting holds every stage register
  assign freeze = (imem.rd & imem.waitrequest) |
                  ((dmem.rd | dmem.wr) & dmem.waitrequest);
  assign halt_now = w_valid_q & w_dec_q.is_halt;

  assign imem.addr    = pc_q;
  assign imem.rd      = running_q;
  assign imem.wr      = 1'b0;       // Instruction port is read only
  assign imem.wr_data = '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q      <= '0;
      running_q <= 1'b0;
      d_valid_q <= 1'b0;
    end else if (!freeze) begin
      running_q <= ~(halted_q | halt_now);
      d_valid_q <= running_q & ~take_branch & ~halt_now;  // Wrong-path fetch dropped
      if (running_q)
        pc_q <= take_branch ? br_target : pc_q + 32'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (!freeze) begin
      d_instr_q <= imem.rd_data;
      d_pc_q    <= pc_q;
    end
  end

  decoder DEC (
    .instr (d_instr_q),
    .dec   (d_dec)
  );

  assign rf_rd_addr1 = d_dec.rs1;
  assign rf_rd_addr2 = d_dec.rs2;

  // Halt in writeback squashes everything younger
  always_ff @(posedge clock) begin
    if (reset) begin
      e_valid_q <= 1'b0;
      w_valid_q <= 1'b0;
      halted_q  <= 1'b0;
    end else if (!freeze) begin
      e_valid_q <= d_valid_q & ~take_branch & ~halt_now;
      w_valid_q <= e_valid_q & ~halt_now;
      if (halt_now)
        halted_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!freeze) begin
      e_dec_q   <= d_dec;
      e_pc_q    <= d_pc_q;
      e_a_q     <= rf_rd_data1;
      e_b_q     <= rf_rd_data2;
      w_dec_q   <= e_dec_q;
      w_alu_q   <= alu_res;
      w_store_q <= fwd_b;
    end
  end

  // Forward the writeback result into execute
  assign w_fwd_ok = w_valid_q & w_dec_q.reg_write & (w_dec_q.rd != '0);
  assign fwd_a = (w_fwd_ok && w_dec_q.rd == e_dec_q.rs1) ? w_result : e_a_q;
  assign fwd_b = (w_fwd_ok && e_dec_q.uses_rs2 && w_dec_q.rd == e_dec_q.rs2) ?
                 w_result : e_b_q;

  always_comb begin
    case (e_dec_q.op)
      OP_ADD:                alu_res = fwd_a + fwd_b;
      OP_SUB:                alu_res = fwd_a - fwd_b;
      OP_AND:                alu_res = fwd_a & fwd_b;
      OP_OR:                 alu_res = fwd_a | fwd_b;
      OP_XOR:                alu_res = fwd_a ^ fwd_b;
      OP_SLT:                alu_res = {31'b0, $signed(fwd_a) < $signed(fwd_b)};
      OP_ADDI, OP_LW, OP_SW: alu_res = fwd_a + e_dec_q.imm;  // Also the memory address
      default:               alu_res = '0;
    endcase
  end

  // beq taken on equal, bne on not equal
  assign take_branch = e_valid_q & e_dec_q.is_branch &
                       ((e_dec_q.op == OP_BEQ) == (fwd_a == fwd_b));
  assign br_target = e_pc_q + 32'd4 + {e_dec_q.imm[29:0], 2'b00};

  assign dmem.addr    = w_alu_q;
  assign dmem.rd      = w_valid_q & w_dec_q.mem_read;
  assign dmem.wr      = w_valid_q & w_dec_q.mem_write;
  assign dmem.wr_data = w_store_q;

  assign w_result     = w_dec_q.mem_read ? dmem.rd_data : w_alu_q;
  assign rf_wr_enable = w_valid_q & w_dec_q.reg_write & ~freeze;
  assign rf_wr_addr   = w_dec_q.rd;
  assign rf_wr_data   = w_result;
  assign halted       = halted_q;

  // Fetch must hold its address until ITCM answers
  a_imem_stable: assert property (@(posedge clock) disable iff (reset)
    imem.rd && imem.waitrequest |=> imem.rd && $stable(imem.addr));

  // Once halted, the core stays quiet until reset
  a_halt_quiet: assert property (@(posedge clock) disable iff (reset)
    halted_q |=> halted_q && !rf_wr_enable && !dmem.wr && !imem.rd);

  a_dmem_cmd: assert property (@(posedge clock) disable iff (reset)
    !(dmem.rd && dmem.wr));

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_core_top
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f pip_core.f -o "V$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
  echo "Result: PASS"
  exit 0
fi
echo "Result: FAIL"
exit 1

/* test/tb_programs.svh */
// Test programs, preload data and expected register contents
// exp_val gives every register, zero where not listed

localparam int NUM_TESTS  = 6;
localparam int PROG_WORDS = 16;
localparam int DATA_WORDS = 4;

word_t prog      [NUM_TESTS][PROG_WORDS];
word_t data      [NUM_TESTS][DATA_WORDS];
word_t exp_val   [NUM_TESTS][32];
string test_name [NUM_TESTS];

// rd = rs1 op rs2
function automatic word_t enc_r(input opcode_e op, input int rd, input int rs1, input int rs2);
  return (word_t'(op) << OPCODE_LSB) | (word_t'(rd) << RD_LSB) |
         (word_t'(rs1) << RS1_LSB) | (word_t'(rs2) << RS2_LSB);
endfunction

function automatic word_t enc_i(input opcode_e op, input int rd, input int rs1, input int imm);
  return (word_t'(op) << OPCODE_LSB) | (word_t'(rd) << RD_LSB) |
         (word_t'(rs1) << RS1_LSB) | ((word_t'(imm) & 32'h0000_FFFF) << IMM_LSB);
endfunction

// rs2 lives inside the immediate, so the base register has to cancel rs2 << 11
function automatic word_t enc_sw(input int rs1, input int rs2, input int off);
  return enc_i(OP_SW, 0, rs1, (rs2 << (RS2_LSB - IMM_LSB)) | off);
endfunction

task automatic fill_table();
  test_name[0] = "alu_forward";  // Each result feeds the next one
  prog[0] = '{0: enc_i(OP_ADDI, 1, 0, 12), 1: enc_i(OP_ADDI, 2, 1, -5),
              2: enc_r(OP_ADD, 3, 1, 2), 3: enc_r(OP_SUB, 4, 3, 1),
              4: enc_r(OP_AND, 5, 4, 3), 5: enc_r(OP_OR, 6, 5, 3),
              6: enc_r(OP_XOR, 7, 6, 2), 7: enc_r(OP_SLT, 8, 2, 7),
              8: enc_r(OP_SUB, 9, 0, 3), 9: enc_r(OP_SLT, 10, 7, 9),
              10: enc_r(OP_SLT, 11, 9, 8), 11: enc_i(OP_HALT, 0, 0, 0), default: '0};
  data[0] = '{default: '0};
  exp_val[0] = '{1: 12, 2: 7, 3: 19, 4: 7, 5: 3, 6: 19, 7: 20, 8: 1,
                 9: 32'hFFFF_FFED, 10: 0, 11: 1, default: '0};

  test_name[1] = "load_sum";  // Data words and r1 to r6 filled at run time
  prog[1] = '{0: enc_i(OP_LW, 1, 0, 0), 1: enc_i(OP_LW, 2, 0, 4),
              2: enc_i(OP_LW, 3, 0, 8), 3: enc_i(OP_LW, 4, 0, 12),
              4: enc_r(OP_ADD, 5, 1, 2), 5: enc_r(OP_ADD, 5, 5, 3),
              6: enc_r(OP_ADD, 5, 5, 4),
              7: enc_i(OP_ADDI, 7, 0, 16 - (5 << 11)),  // Base for word 4
              8: enc_sw(7, 5, 0), 9: enc_i(OP_LW, 6, 0, 16),
              10: enc_i(OP_HALT, 0, 0, 0), default: '0};
  exp_val[1] = '{7: 32'hFFFF_D810, default: '0};

  test_name[2] = "branches";
  prog[2] = '{0: enc_i(OP_ADDI, 1, 0, 5), 1: enc_i(OP_BEQ, 0, 0, 2),
              2: enc_i(OP_ADDI, 2, 0, 1), 3: enc_i(OP_ADDI, 3, 0, 1),
              4: enc_i(OP_BNE, 0, 1, 1), 5: enc_i(OP_ADDI, 4, 0, 1),
              6: enc_i(OP_BEQ, 0, 1, 1), 7: enc_i(OP_ADDI, 5, 0, 7),
              8: enc_i(OP_BNE, 0, 0, 1), 9: enc_i(OP_ADDI, 6, 0, 9),
              10: enc_i(OP_HALT, 0, 0, 0), default: '0};
  data[2] = '{default: '0};
  exp_val[2] = '{1: 5, 5: 7, 6: 9, default: '0};

  test_name[3] = "reg_zero";
  prog[3] = '{0: enc_i(OP_ADDI, 0, 0, 77), 1: enc_i(OP_ADDI, 1, 0, 3),
              2: enc_r(OP_ADD, 0, 1, 1), 3: enc_r(OP_ADD, 2, 0, 1),
              4: enc_i(OP_LW, 0, 0, 0), 5: enc_r(OP_ADD, 3, 0, 0),
              6: enc_i(OP_HALT, 0, 0, 0), default: '0};
  data[3] = '{0: 32'h0000_0055, default: '0};
  exp_val[3] = '{1: 3, 2: 3, default: '0};

  test_name[4] = "halt_stop";  // Words after the halt must do nothing
  prog[4] = '{0: enc_i(OP_ADDI, 1, 0, 1), 1: enc_i(OP_ADDI, 2, 1, 1),
              2: enc_i(OP_HALT, 0, 0, 0), 3: enc_i(OP_ADDI, 3, 0, 33),
              4: enc_i(OP_ADDI, 1, 0, 99), 5: enc_i(OP_ADDI, 4, 0, 44), default: '0};
  data[4] = '{default: '0};
  exp_val[4] = '{1: 1, 2: 2, default: '0};

  test_name[5] = "rerun_clean";  // r1 and r2 were set by the run before
  prog[5] = '{0: enc_r(OP_ADD, 3, 1, 2), 1: enc_i(OP_ADDI, 4, 3, 6),
              2: enc_i(OP_HALT, 0, 0, 0), default: '0};
  data[5] = '{default: '0};
  exp_val[5] = '{4: 6, default: '0};
endtask

/* test/tb_core_top.sv */
`timescale 1ns/1ps

module tb_core_top;
  import pip_types::*;

  `include "tb_programs.svh"

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 5;
  localparam int HOLD_CYCLES     = 20;   // halted must stay high this long
  localparam int SEED            = 9;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * PROG_WORDS * 12;

  logic      clock;
  logic      reset;
  logic      imem_load;
  word_t     imem_load_addr;
  word_t     imem_load_data;
  logic      dmem_load;
  word_t     dmem_load_addr;
  word_t     dmem_load_data;
  reg_addr_t dbg_addr;
  word_t     dbg_data;
  logic      halted;

  int errors;
  int test_errors;
  int passed_tests;

  core_top DUT (
    .clock          (clock),
    .reset          (reset),
    .imem_load      (imem_load),
    .imem_load_addr (imem_load_addr),
    .imem_load_data (imem_load_data),
    .dmem_load      (dmem_load),
    .dmem_load_addr (dmem_load_addr),
    .dmem_load_data (dmem_load_data),
    .dbg_addr       (dbg_addr),
    .dbg_data       (dbg_data),
    .halted         (halted)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the core never reached halt", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  // Inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic check_value(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("FAIL @%0t: %s got %h, expected %h", $time, what, actual, expected);
      test_errors++;
    end
  endtask

  // Random words for the load test, expected values by 32-bit add rules
  task automatic randomize_sum_test();
    word_t sum;
    sum = '0;
    for (int i = 0; i < DATA_WORDS; i++) begin
      data[1][i] = $urandom();
      exp_val[1][i + 1] = data[1][i];
      sum = sum + data[1][i];
    end
    exp_val[1][5] = sum;
    exp_val[1][6] = sum;  // Reloaded after the store
  endtask

  task automatic run_test(input int t);
    test_errors = 0;
    reset = 1'b1;
    // Reset spans the load and five more cycles
    for (int i = 0; i < PROG_WORDS; i++) begin
      imem_load      = 1'b1;
      imem_load_addr = word_t'(i);
      imem_load_data = prog[t][i];
      dmem_load      = (i < DATA_WORDS);
      dmem_load_addr = word_t'(i % DATA_WORDS);
      dmem_load_data = data[t][i % DATA_WORDS];
      step();
    end
    imem_load = 1'b0;
    dmem_load = 1'b0;
    repeat (RESET_CYCLES) step();
    reset = 1'b0;
    while (halted !== 1'b1)
      step();
    for (int n = 0; n < HOLD_CYCLES; n++) begin
      step();
      check_value(word_t'(halted), 32'd1, "halted held after halt");
    end
    for (int r = 0; r < 32; r++) begin
      dbg_addr = reg_addr_t'(r);
      step();
      check_value(dbg_data, exp_val[t][r], $sformatf("%s r%0d", test_name[t], r));
    end
    $display("Test %0d %-12s %0d mismatches", t, test_name[t], test_errors);
  endtask

  initial begin
    void'($urandom(SEED));
    reset          = 1'b1;
    imem_load      = 1'b0;
    imem_load_addr = '0;
    imem_load_data = '0;
    dmem_load      = 1'b0;
    dmem_load_addr = '0;
    dmem_load_data = '0;
    dbg_addr       = '0;
    errors         = 0;
    passed_tests   = 0;
    fill_table();
    randomize_sum_test();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
      errors = errors + test_errors;
      if (test_errors == 0)
        passed_tests++;
    end
    $display("Summary: %0d of %0d tests passed, %0d mismatches", passed_tests, NUM_TESTS,
             errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
